//--- run_sim.sh
#!/bin/sh
# Build and run the decoder testbench with Verilator.
# The exit status is nonzero when the build fails or the run ends in $fatal.

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f zap_thumb_decoder.f \
        --top-module zap_thumb_decoder_tb -o zap_thumb_decoder_sim &&
./obj_dir/zap_thumb_decoder_sim +verilator+error+limit+1000 ||
{ echo "Simulation failed"; exit 1; }

//--- sim/zap_thumb_decoder_assert.sv
// Checker bound to the decoder top level
// Holds the previous cycle's inputs
// Expected expansion of a halfword, built from the ARM encodings
// Concurrent assertions on reset, valid, pass-through, expansion and flags

`include "zap_thumb_defs.svh"

`default_nettype none

module zap_thumb_decoder_assert (
        input  logic                           i_clk,
        input  logic                           i_rst_n,
        input  logic [`ZAP_INSTR_W-1:0]        i_instruction,
        input  logic                           i_instruction_valid,
        input  logic                           i_cpsr_ff_t,
        input  logic [`ZAP_INSTR_W-1:0]        i_out_instruction,     // DUT outputs
        input  logic                           i_out_valid,
        input  logic                           i_out_und,
        input  logic                           i_out_branch_halfword
);

int fail_count = 0;                             // Read by the testbench

logic [`ZAP_INSTR_W-1:0] prev_instr;
logic                    prev_valid;
logic                    prev_t;
logic [33:0]             exp_all;               // {und, halfword flag, instr}

//////////////////////////////
// Expected values
//////////////////////////////

// Data processing, register operand, no shift
function automatic logic [31:0] dp_reg(input logic [3:0] opc, input logic s,
                                       input logic [3:0] rn, input logic [3:0] rd,
                                       input logic [3:0] rm);
        return {zap_thumb_pkg::AL, 3'b000, opc, s, rn, rd, 8'd0, rm};
endfunction

// MOVS Rd, Rd, <sh> Rs
function automatic logic [31:0] mov_reg_shift(input logic [3:0] rd, input logic [3:0] rs,
                                              input logic [1:0] sh);
        return {zap_thumb_pkg::AL, 3'b000, zap_thumb_pkg::ALU_MOV, 1'b1, rd, rd, rs,
                1'b0, sh, 1'b1, rd};
endfunction

function automatic logic [33:0] expected_expansion(input logic [15:0] hw);
        logic [3:0]  rd_l;      // Low regs widened
        logic [3:0]  rs_l;
        logic [3:0]  rd_8;      // Rd of imm8 forms
        logic [3:0]  rd_h;      // H1 on top
        logic [3:0]  rm_h;      // H2 on top
        logic [3:0]  opc;
        logic [31:0] ins;
        logic        und;
        logic        bhw;

        rd_l = {1'b0, hw[2:0]};
        rs_l = {1'b0, hw[5:3]};
        rd_8 = {1'b0, hw[10:8]};
        rd_h = {hw[7], hw[2:0]};
        rm_h = {hw[6], hw[5:3]};
        opc  = 4'd0;
        ins  = 32'd0;
        und  = 1'b0;
        bhw  = 1'b0;

        if (hw[15:8] == 8'hDF)                  // SWI imm8
                ins = {zap_thumb_pkg::AL, 4'hF, 16'd0, hw[7:0]};
        else if (hw[15:12] == 4'hD)             // Bcc
        begin
                ins = {hw[11:8], 4'b1010, {16{hw[7]}}, hw[7:0]};
                bhw = 1'b1;
        end
        else if (hw[15:11] == 5'b11100)         // B
        begin
                ins = {zap_thumb_pkg::AL, 4'b1010, {13{hw[10]}}, hw[10:0]};
                bhw = 1'b1;
        end
        else if (hw[15:11] == 5'b00011)         // ADD/SUB, imm3 or Rm in 8:6
        begin
                opc = hw[9] ? zap_thumb_pkg::ALU_SUB : zap_thumb_pkg::ALU_ADD;
                ins = {zap_thumb_pkg::AL, 2'b00, hw[10], opc, 1'b1, rs_l, rd_l, 9'd0, hw[8:6]};
        end
        else if (hw[15:13] == 3'b000)           // Shift by imm5
                ins = {zap_thumb_pkg::AL, 3'b000, zap_thumb_pkg::ALU_MOV, 1'b1, 4'd0, rd_l,
                       hw[10:6], hw[12:11], 1'b0, rs_l};
        else if (hw[15:13] == 3'b001)
        begin
                case (hw[12:11])
                2'd0:    opc = zap_thumb_pkg::ALU_MOV;
                2'd1:    opc = zap_thumb_pkg::ALU_CMP;
                2'd2:    opc = zap_thumb_pkg::ALU_ADD;
                default: opc = zap_thumb_pkg::ALU_SUB;
                endcase
                ins = {zap_thumb_pkg::AL, 2'b00, 1'b1, opc, 1'b1, rd_8, rd_8, 4'd0, hw[7:0]};
        end
        else if (hw[15:10] == 6'b010000)        // Low register ALU
        begin
                case (hw[9:6])
                4'd0:  ins = dp_reg(zap_thumb_pkg::ALU_AND, 1'b1, rd_l, rd_l, rs_l);
                4'd1:  ins = dp_reg(zap_thumb_pkg::ALU_EOR, 1'b1, rd_l, rd_l, rs_l);
                4'd2:  ins = mov_reg_shift(rd_l, rs_l, zap_thumb_pkg::LSL);
                4'd3:  ins = mov_reg_shift(rd_l, rs_l, zap_thumb_pkg::LSR);
                4'd4:  ins = mov_reg_shift(rd_l, rs_l, zap_thumb_pkg::ASR);
                4'd5:  ins = dp_reg(zap_thumb_pkg::ALU_ADC, 1'b1, rd_l, rd_l, rs_l);
                4'd6:  ins = dp_reg(zap_thumb_pkg::ALU_SBC, 1'b1, rd_l, rd_l, rs_l);
                4'd7:  ins = mov_reg_shift(rd_l, rs_l, zap_thumb_pkg::ROR);
                4'd8:  ins = dp_reg(zap_thumb_pkg::ALU_TST, 1'b1, rd_l, rd_l, rs_l);
                4'd9:  ins = {zap_thumb_pkg::AL, 3'b001, zap_thumb_pkg::ALU_RSB, 1'b1,
                              rs_l, rd_l, 12'd0};       // NEG is RSBS #0
                4'd10: ins = dp_reg(zap_thumb_pkg::ALU_CMP, 1'b1, rd_l, rd_l, rs_l);
                4'd11: ins = dp_reg(zap_thumb_pkg::ALU_CMN, 1'b1, rd_l, rd_l, rs_l);
                4'd12: ins = dp_reg(zap_thumb_pkg::ALU_ORR, 1'b1, rd_l, rd_l, rs_l);
                4'd13: ins = {zap_thumb_pkg::AL, 7'd0, 1'b1, rd_l, 4'd0, rd_l, 4'b1001,
                              rs_l};                    // MULS
                4'd14: ins = dp_reg(zap_thumb_pkg::ALU_BIC, 1'b1, rd_l, rd_l, rs_l);
                default: ins = dp_reg(zap_thumb_pkg::ALU_MVN, 1'b1, rd_l, rd_l, rs_l);
                endcase
        end
        else if (hw[15:10] == 6'b010001)        // High registers and BX
        begin
                if (hw[9:8] == 2'b11 && !hw[7])
                        ins = {zap_thumb_pkg::AL, 24'h12_FFF1, hw[6:3]};
                else if (hw[9:8] == 2'b11)
                        und = 1'b1;             // BLX2
                else if (hw[9:8] == 2'b01)
                        ins = dp_reg(zap_thumb_pkg::ALU_CMP, 1'b1, rd_h, rd_h, rm_h);
                else if (hw[9:8] == 2'b00)
                        ins = dp_reg(zap_thumb_pkg::ALU_ADD, 1'b0, rd_h, rd_h, rm_h);
                else
                        ins = dp_reg(zap_thumb_pkg::ALU_MOV, 1'b0, rd_h, rd_h, rm_h);
        end
        else
                und = 1'b1;                     // Memory ops, BL, BKPT

        return {und, bhw, ins};
endfunction

//////////////////////////////
// Previous cycle inputs
//////////////////////////////

always_ff @(posedge i_clk or negedge i_rst_n)
begin
        if (!i_rst_n)
        begin
                prev_instr <= '0;
                prev_valid <= 1'b0;
                prev_t     <= 1'b0;
        end
        else
        begin
                prev_instr <= i_instruction;
                prev_valid <= i_instruction_valid;
                prev_t     <= i_cpsr_ff_t;
        end
end

assign exp_all = expected_expansion(prev_instr[15:0]);

//////////////////////////////
// Assertions
//////////////////////////////

// All flags low while reset is held
a_reset_valid: assert property (@(posedge i_clk)
        !i_rst_n |-> !i_out_valid && !i_out_und && !i_out_branch_halfword)
else
begin
        fail_count = fail_count + 1;
        $error("Mismatch at %0t: outputs in reset", $time);
end

a_valid_delay: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_out_valid == prev_valid)
else
begin
        fail_count = fail_count + 1;
        $error("Mismatch at %0t: valid delay", $time);
end

a_pass_through: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        prev_valid && !prev_t |->
        i_out_instruction == prev_instr && !i_out_und && !i_out_branch_halfword)
else
begin
        fail_count = fail_count + 1;
        $error("Mismatch at %0t: pass-through", $time);
end

a_expand_instr: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        prev_valid && prev_t && !exp_all[33] |-> i_out_instruction == exp_all[31:0])
else
begin
        fail_count = fail_count + 1;
        $error("Mismatch at %0t: o_instruction", $time);
end

a_expand_flags: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        prev_valid && prev_t |->
        i_out_und == exp_all[33] && i_out_branch_halfword == exp_all[32])
else
begin
        fail_count = fail_count + 1;
        $error("Mismatch at %0t: o_und/flag", $time);
end

a_idle_flags: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !prev_valid |-> !i_out_und && !i_out_branch_halfword)
else
begin
        fail_count = fail_count + 1;
        $error("Mismatch at %0t: idle flags", $time);
end

endmodule

bind zap_thumb_decoder zap_thumb_decoder_assert u_assert (
        .i_clk                  (i_clk),
        .i_rst_n                (i_rst_n),
        .i_instruction          (i_instruction),
        .i_instruction_valid    (i_instruction_valid),
        .i_cpsr_ff_t            (i_cpsr_ff_t),
        .i_out_instruction      (o_instruction),
        .i_out_valid            (o_instruction_valid),
        .i_out_und              (o_und),
        .i_out_branch_halfword  (o_branch_halfword)
);

`default_nettype wire

//--- sim/zap_thumb_decoder_tb.sv
// Testbench for the compressed instruction decoder
// Clock, reset, directed vectors then LFSR driven vectors
// Failure watch on the bound checker, watchdog, pass message

`include "zap_thumb_defs.svh"

`default_nettype none

module zap_thumb_decoder_tb;

localparam int CLK_PERIOD = 40;
localparam int N_FIXED    = 29;
localparam int N_DIRECTED = N_FIXED + 16 + 4;   // Fixed, ALU lo, ARM, reset and idle
localparam int N_RANDOM   = 600;
localparam int WATCHDOG   = (N_DIRECTED + N_RANDOM + 10) * CLK_PERIOD * 2;

logic                    i_clk;
logic                    i_rst_n;
logic [`ZAP_INSTR_W-1:0] i_instruction;
logic                    i_instruction_valid;
logic                    i_cpsr_ff_t;
logic [`ZAP_INSTR_W-1:0] o_instruction;
logic                    o_instruction_valid;
logic                    o_und;
logic                    o_branch_halfword;

logic [15:0]             lfsr_state;

// T mode halfwords, one group per line
logic [15:0] fixed_vec [N_FIXED] = '{
        16'h0123, 16'h0ABC, 16'h1745,                   // LSL, LSR, ASR imm5
        16'h1888, 16'h1A51, 16'h1C5A, 16'h1FFF,         // ADD/SUB reg and imm3
        16'h2155, 16'h2A80, 16'h3312, 16'h3FFF,         // MOV, CMP, ADD, SUB imm8
        16'h4488, 16'h45F0, 16'h4677,                   // Hi ADD, CMP, MOV
        16'h4770, 16'h4708, 16'h47C8,                   // BX twice, then BLX2
        16'hD0FE, 16'hD705, 16'hDEAA,                   // Bcc
        16'hE7FE, 16'hE123,                             // B, one negative
        16'hDF42, 16'hDFFF,                             // SWI
        16'h6808, 16'hF000, 16'hB500, 16'hBE01, 16'hE800
};

zap_thumb_decoder u_zap_thumb_decoder (
        .i_clk                  (i_clk),
        .i_rst_n                (i_rst_n),
        .i_instruction          (i_instruction),
        .i_instruction_valid    (i_instruction_valid),
        .i_cpsr_ff_t            (i_cpsr_ff_t),
        .o_instruction          (o_instruction),
        .o_instruction_valid    (o_instruction_valid),
        .o_und                  (o_und),
        .o_branch_halfword      (o_branch_halfword)
);

//////////////////////////////
// Helpers
//////////////////////////////

// Galois form, taps 16,14,13,11
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
endfunction

task automatic take_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int k = 0; k < n; k++)
        begin
                value      = {value[30:0], lfsr_state[0]};
                lfsr_state = lfsr_next(lfsr_state);     // One step per bit
        end
endtask

task automatic drive_input(input logic [31:0] instr, input logic t, input logic valid);
        @(negedge i_clk);
        i_instruction       = instr;
        i_cpsr_ff_t         = t;
        i_instruction_valid = valid;
endtask

//////////////////////////////
// Clock, watch and watchdog
//////////////////////////////

initial
begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
end

initial
begin
        wait (u_zap_thumb_decoder.u_assert.fail_count != 0);
        $display("*** TEST FAILED ***");
        $fatal(1, "The checker bound to the DUT reported a failing assertion");
end

initial
begin
        #(WATCHDOG);
        $display("*** TEST FAILED ***");
        $fatal(1, "Watchdog expired before all vectors were applied");
end

//////////////////////////////
// Stimulus
//////////////////////////////

initial
begin
        logic [31:0] lo_bits;
        logic [31:0] hi_bits;
        logic [31:0] ctl_bits;
        logic [3:0]  alu_op;

        i_rst_n             = 1'b0;
        i_instruction       = '0;
        i_instruction_valid = 1'b0;
        i_cpsr_ff_t         = 1'b0;
        lfsr_state          = 16'd20;   // Seed
        repeat (2) @(posedge i_clk);
        @(negedge i_clk);
        i_rst_n = 1'b1;

        for (int k = 0; k < N_FIXED; k++)
                drive_input({16'hFFFF, fixed_vec[k]}, 1'b1, 1'b1);     // Upper half ignored

        for (int k = 0; k < 16; k++)
        begin
                alu_op = k[3:0];
                drive_input({16'h0000, 6'b010000, alu_op, 3'd5, 3'd2}, 1'b1, 1'b1);
        end

        drive_input(32'hE1A0_0001, 1'b0, 1'b1);         // ARM words pass through
        drive_input(32'hE592_1004, 1'b0, 1'b1);

        // Branch in flight, then reset with valid still high
        drive_input({16'h0000, 16'hD0FE}, 1'b1, 1'b1);
        @(negedge i_clk);
        i_rst_n = 1'b0;
        repeat (2) @(posedge i_clk);
        @(negedge i_clk);
        i_rst_n = 1'b1;

        drive_input({16'h0000, 16'h6808}, 1'b1, 1'b0);  // Undefined but not valid

        for (int k = 0; k < N_RANDOM; k++)
        begin
                take_bits(16, lo_bits);
                take_bits(16, hi_bits);
                take_bits(3, ctl_bits);
                drive_input({hi_bits[15:0], lo_bits[15:0]}, |ctl_bits[1:0], ctl_bits[2]);
        end

        drive_input(32'd0, 1'b0, 1'b0);
        @(negedge i_clk);                               // Last item checked by now

        if (u_zap_thumb_decoder.u_assert.fail_count != 0)
        begin
                $display("*** TEST FAILED ***");
                $fatal(1, "Failing assertions were counted by the end of the run");
        end
        else
        begin
                $display("*** TEST PASSED ***");
                $finish;
        end
end

endmodule

`default_nettype wire

//--- src/zap_thumb_branch_decoder.sv
// Control flow expander
// Conditional and unconditional branch, BX and SWI
// Flags branches whose offset counts halfwords

`include "zap_thumb_defs.svh"

`default_nettype none

module zap_thumb_branch_decoder (
        input  logic [`ZAP_THUMB_W-1:0]        i_halfword,
        input  zap_thumb_pkg::thumb_class_t    i_class,

        output logic [`ZAP_INSTR_W-1:0]        o_instruction,
        output logic                           o_branch_halfword   // Offset in halfwords
);

always_comb
begin
        o_instruction     = '0;
        o_branch_halfword = 1'b0;

        case ( i_class )
        zap_thumb_pkg::CLS_BRANCH_COND:
        begin
                // Condition from 11:8, offset8 sign extended
                o_instruction     = {i_halfword[11:8], `ZAP_BRANCH_ID, 1'b0,
                                     {16{i_halfword[7]}}, i_halfword[7:0]};
                o_branch_halfword = 1'b1;
        end
        zap_thumb_pkg::CLS_BRANCH_NOCOND:
        begin
                o_instruction     = {zap_thumb_pkg::AL, `ZAP_BRANCH_ID, 1'b0,
                                     {13{i_halfword[10]}}, i_halfword[10:0]}; // offset11
                o_branch_halfword = 1'b1;
        end
        zap_thumb_pkg::CLS_BX:
        begin
                // Rm with H2 on top
                o_instruction = {zap_thumb_pkg::AL, `ZAP_BX_BODY, i_halfword[6:3]};
        end
        zap_thumb_pkg::CLS_SWI:
        begin
                o_instruction = {zap_thumb_pkg::AL, `ZAP_SWI_ID, 16'd0, i_halfword[7:0]};
        end
        default:
        begin
                o_instruction = '0;     // Not a control flow class
        end
        endcase
end

endmodule

`default_nettype wire

//--- src/zap_thumb_class_decoder.sv
// Format matcher for compressed halfwords
// Names the class of a kept format, in priority order
// Flags everything else as undefined, including high register op 3

`include "zap_thumb_defs.svh"

`default_nettype none

module zap_thumb_class_decoder (
        input  logic [`ZAP_THUMB_W-1:0]        i_halfword,     // Low half of fetch

        output zap_thumb_pkg::thumb_class_t    o_class,
        output logic                           o_und           // No kept format
);

////////////////////////////////
// Format match
////////////////////////////////

// Case items are tried top down, so overlapping patterns
// must keep this order
always_comb
begin
        o_class = zap_thumb_pkg::CLS_NONE;
        o_und   = 1'b0;

        casez ( i_halfword )
        16'b1101_1111_????_????: // SWI, ahead of conditional branch
                o_class = zap_thumb_pkg::CLS_SWI;
        16'b0001_1???_????_????: // ADD/SUB lo, ahead of shift
                o_class = zap_thumb_pkg::CLS_ADD_SUB_LO;
        16'b0100_0111_0???_????: // BX, ahead of hi reg ops
                o_class = zap_thumb_pkg::CLS_BX;
        16'b1101_????_????_????:
                o_class = zap_thumb_pkg::CLS_BRANCH_COND;
        16'b1110_0???_????_????:
                o_class = zap_thumb_pkg::CLS_BRANCH_NOCOND;
        16'b000?_????_????_????: // LSL/LSR/ASR imm5
                o_class = zap_thumb_pkg::CLS_SHIFT;
        16'b001?_????_????_????:
                o_class = zap_thumb_pkg::CLS_MCAS_IMM;
        16'b0100_00??_????_????:
                o_class = zap_thumb_pkg::CLS_ALU_LO;
        16'b0100_01??_????_????:
        begin
                // Op 3 left here is BLX2, not kept
                if ( i_halfword[9:8] == 2'b11 )
                begin
                        o_und = 1'b1;
                end
                else
                begin
                        o_class = zap_thumb_pkg::CLS_ALU_HI;
                end
        end
        default:
        begin
                // Loads, stores, stack, BL, BKPT and friends
                o_und = 1'b1;
        end
        endcase
end

endmodule

`default_nettype wire

//--- src/zap_thumb_decode_stage.sv
// Output stage of the decoder
// Pass-through of 32-bit instructions when T is clear
// Selection of the expanded instruction by class
// Single register stage on all outputs

`include "zap_thumb_defs.svh"

`default_nettype none

module zap_thumb_decode_stage (
        input  logic                           i_clk,
        input  logic                           i_rst_n,

        input  logic [`ZAP_INSTR_W-1:0]        i_instruction,
        input  logic                           i_instruction_valid,
        input  logic                           i_cpsr_ff_t,    // Compressed mode

        input  zap_thumb_pkg::thumb_class_t    i_class,
        input  logic                           i_und,
        input  logic [`ZAP_INSTR_W-1:0]        i_dp_instruction,
        input  logic [`ZAP_INSTR_W-1:0]        i_br_instruction,
        input  logic                           i_br_halfword,

        output logic [`ZAP_INSTR_W-1:0]        o_instruction,
        output logic                           o_instruction_valid,
        output logic                           o_und,
        output logic                           o_branch_halfword
);

logic                    expand;        // Valid and compressed
logic [`ZAP_INSTR_W-1:0] nxt_instr;

assign expand = i_instruction_valid & i_cpsr_ff_t;

////////////////////////////////
// Next instruction
////////////////////////////////

always_comb
begin
        nxt_instr = i_instruction;      // Raw word, also for undefined

        if ( expand )
        begin
                case ( i_class )
                zap_thumb_pkg::CLS_SHIFT, zap_thumb_pkg::CLS_ADD_SUB_LO,
                zap_thumb_pkg::CLS_MCAS_IMM, zap_thumb_pkg::CLS_ALU_LO,
                zap_thumb_pkg::CLS_ALU_HI:
                        nxt_instr = i_dp_instruction;
                zap_thumb_pkg::CLS_BRANCH_COND, zap_thumb_pkg::CLS_BRANCH_NOCOND,
                zap_thumb_pkg::CLS_BX, zap_thumb_pkg::CLS_SWI:
                        nxt_instr = i_br_instruction;
                default:
                        nxt_instr = i_instruction;
                endcase
        end
end

////////////////////////////////
// Output registers
////////////////////////////////

always_ff @ ( posedge i_clk or negedge i_rst_n )
begin
        if ( !i_rst_n )
        begin
                o_instruction_valid <= 1'b0;
                o_und               <= 1'b0;
                o_branch_halfword   <= 1'b0;
        end
        else
        begin
                o_instruction_valid <= i_instruction_valid;
                o_und               <= expand & i_und;          // 0 in ARM mode
                o_branch_halfword   <= expand & i_br_halfword;
        end
end

always_ff @ ( posedge i_clk )
begin
        o_instruction <= nxt_instr;     // Loads every cycle
end

endmodule

`default_nettype wire

//--- src/zap_thumb_decoder.sv
// Top level of the compressed instruction decoder
// Class matcher, DP and control flow expanders, output stage

`include "zap_thumb_defs.svh"

`default_nettype none

module zap_thumb_decoder (
        input  logic                           i_clk,
        input  logic                           i_rst_n,

        input  logic [`ZAP_INSTR_W-1:0]        i_instruction,  // From I-cache
        input  logic                           i_instruction_valid,
        input  logic                           i_cpsr_ff_t,    // T bit

        output logic [`ZAP_INSTR_W-1:0]        o_instruction,  // To 32-bit decode
        output logic                           o_instruction_valid,
        output logic                           o_und,
        output logic                           o_branch_halfword
);

zap_thumb_pkg::thumb_class_t   cls;
logic                          und;
logic [`ZAP_INSTR_W-1:0]       dp_instr;
logic [`ZAP_INSTR_W-1:0]       br_instr;
logic                          br_halfword;

zap_thumb_class_decoder u_class (
        .i_halfword             (i_instruction[`ZAP_THUMB_W-1:0]),
        .o_class                (cls),
        .o_und                  (und)
);

zap_thumb_dp_decoder u_dp (
        .i_halfword             (i_instruction[`ZAP_THUMB_W-1:0]),
        .i_class                (cls),
        .o_instruction          (dp_instr)
);

zap_thumb_branch_decoder u_branch (
        .i_halfword             (i_instruction[`ZAP_THUMB_W-1:0]),
        .i_class                (cls),
        .o_instruction          (br_instr),
        .o_branch_halfword      (br_halfword)
);

zap_thumb_decode_stage u_stage (
        .i_clk                  (i_clk),
        .i_rst_n                (i_rst_n),
        .i_instruction          (i_instruction),
        .i_instruction_valid    (i_instruction_valid),
        .i_cpsr_ff_t            (i_cpsr_ff_t),
        .i_class                (cls),
        .i_und                  (und),
        .i_dp_instruction       (dp_instr),
        .i_br_instruction       (br_instr),
        .i_br_halfword          (br_halfword),
        .o_instruction          (o_instruction),
        .o_instruction_valid    (o_instruction_valid),
        .o_und                  (o_und),
        .o_branch_halfword      (o_branch_halfword)
);

endmodule

`default_nettype wire

//--- src/zap_thumb_defs.svh
// Width and encoding macros for the compressed instruction decoder
// Instruction widths, architectural register numbers
// Fixed fields of the expanded branch, SWI and BX instructions

`ifndef ZAP_THUMB_DEFS_SVH
`define ZAP_THUMB_DEFS_SVH

`default_nettype none

////////////////////////////////
// Widths
////////////////////////////////

`define ZAP_INSTR_W     32      // Full instruction
`define ZAP_THUMB_W     16      // Compressed halfword

////////////////////////////////
// Register numbers
////////////////////////////////

`define ZAP_REG_SP      4'd13
`define ZAP_REG_PC      4'd15

////////////////////////////////
// Fixed encoding fields
////////////////////////////////

`define ZAP_BRANCH_ID   3'b101  // Bits 27:25 of B/BL
`define ZAP_SWI_ID      4'b1111 // Bits 27:24 of SWI

// Bits 27:4 of BX, Rm goes below
`define ZAP_BX_BODY     24'b0001_0010_1111_1111_1111_0001

`default_nettype wire

`endif

//--- src/zap_thumb_dp_decoder.sv
// Data processing expander
// Shift by immediate, ADD/SUB lo, MOV/CMP/ADD/SUB imm8
// Low register ALU ops and high register ADD/CMP/MOV
// Output is zero for any other class

`include "zap_thumb_defs.svh"

`default_nettype none

module zap_thumb_dp_decoder (
        input  logic [`ZAP_THUMB_W-1:0]        i_halfword,
        input  zap_thumb_pkg::thumb_class_t    i_class,

        output logic [`ZAP_INSTR_W-1:0]        o_instruction   // Expanded DP instr
);

////////////////////////////////
// Register fields
////////////////////////////////

logic [3:0] rd_lo;      // Bits 2:0, zero extended
logic [3:0] rs_lo;      // Bits 5:3
logic [3:0] rd_imm;     // Bits 10:8 of imm8 forms
logic [3:0] rd_hi;      // H1 and bits 2:0
logic [3:0] rs_hi;      // H2 and bits 5:3

assign rd_lo  = {1'b0, i_halfword[2:0]};
assign rs_lo  = {1'b0, i_halfword[5:3]};
assign rd_imm = {1'b0, i_halfword[10:8]};
assign rd_hi  = {i_halfword[7], i_halfword[2:0]};
assign rs_hi  = {i_halfword[6], i_halfword[5:3]};

////////////////////////////////
// Expansion
////////////////////////////////

always_comb
begin
        zap_thumb_pkg::alu_op_t op;     // Opcode for the generic forms
        zap_thumb_pkg::shift_t  sh;     // Shift type of ALU lo shifts

        op            = zap_thumb_pkg::ALU_MOV;
        sh            = zap_thumb_pkg::LSL;
        o_instruction = '0;

        case ( i_class )
        zap_thumb_pkg::CLS_SHIFT:
        begin
                // MOVS Rd, Rs, <sh> #imm5
                o_instruction = {zap_thumb_pkg::AL, 2'b00, 1'b0, zap_thumb_pkg::ALU_MOV,
                                 1'b1, 4'd0, rd_lo, i_halfword[10:6], i_halfword[12:11],
                                 1'b0, rs_lo};
        end
        zap_thumb_pkg::CLS_ADD_SUB_LO:
        begin
                // Rn and imm3 share bits 8:6, bit 10 picks the I bit
                op = i_halfword[9] ? zap_thumb_pkg::ALU_SUB : zap_thumb_pkg::ALU_ADD;
                o_instruction = {zap_thumb_pkg::AL, 2'b00, i_halfword[10], op, 1'b1,
                                 rs_lo, rd_lo, 9'd0, i_halfword[8:6]};
        end
        zap_thumb_pkg::CLS_MCAS_IMM:
        begin
                case ( i_halfword[12:11] )
                2'd0:    op = zap_thumb_pkg::ALU_MOV;
                2'd1:    op = zap_thumb_pkg::ALU_CMP;
                2'd2:    op = zap_thumb_pkg::ALU_ADD;
                default: op = zap_thumb_pkg::ALU_SUB;
                endcase
                o_instruction = {zap_thumb_pkg::AL, 2'b00, 1'b1, op, 1'b1, rd_imm, rd_imm,
                                 4'd0, i_halfword[7:0]};        // imm8 zero extended
        end
        zap_thumb_pkg::CLS_ALU_LO:
        begin
                case ( i_halfword[9:6] )
                4'd0:  op = zap_thumb_pkg::ALU_AND;
                4'd1:  op = zap_thumb_pkg::ALU_EOR;
                4'd2:  sh = zap_thumb_pkg::LSL;
                4'd3:  sh = zap_thumb_pkg::LSR;
                4'd4:  sh = zap_thumb_pkg::ASR;
                4'd5:  op = zap_thumb_pkg::ALU_ADC;
                4'd6:  op = zap_thumb_pkg::ALU_SBC;
                4'd7:  sh = zap_thumb_pkg::ROR;
                4'd8:  op = zap_thumb_pkg::ALU_TST;
                4'd9:  op = zap_thumb_pkg::ALU_RSB;     // NEG
                4'd10: op = zap_thumb_pkg::ALU_CMP;
                4'd11: op = zap_thumb_pkg::ALU_CMN;
                4'd12: op = zap_thumb_pkg::ALU_ORR;
                4'd14: op = zap_thumb_pkg::ALU_BIC;
                4'd15: op = zap_thumb_pkg::ALU_MVN;
                default: op = zap_thumb_pkg::ALU_MOV;   // MUL has its own form
                endcase

                case ( i_halfword[9:6] )
                4'd2, 4'd3, 4'd4, 4'd7: // MOVS Rd, Rd, <sh> Rs
                        o_instruction = {zap_thumb_pkg::AL, 2'b00, 1'b0, op, 1'b1, rd_lo,
                                         rd_lo, rs_lo, 1'b0, sh, 1'b1, rd_lo};
                4'd9:   // RSBS Rd, Rs, #0
                        o_instruction = {zap_thumb_pkg::AL, 2'b00, 1'b1, op, 1'b1, rs_lo,
                                         rd_lo, 12'd0};
                4'd13:  // MULS Rd, Rs, Rd
                        o_instruction = {zap_thumb_pkg::AL, 4'b0000, 3'b000, 1'b1, rd_lo,
                                         4'd0, rd_lo, 4'b1001, rs_lo};
                default:
                        o_instruction = {zap_thumb_pkg::AL, 2'b00, 1'b0, op, 1'b1, rd_lo,
                                         rd_lo, 8'd0, rs_lo};
                endcase
        end
        zap_thumb_pkg::CLS_ALU_HI:
        begin
                // Only CMP sets flags here
                case ( i_halfword[9:8] )
                2'd0:    op = zap_thumb_pkg::ALU_ADD;
                2'd1:    op = zap_thumb_pkg::ALU_CMP;
                default: op = zap_thumb_pkg::ALU_MOV;
                endcase
                o_instruction = {zap_thumb_pkg::AL, 2'b00, 1'b0, op,
                                 i_halfword[9:8] == 2'd1, rd_hi, rd_hi, 8'd0, rs_hi};
        end
        default:
        begin
                o_instruction = '0;     // Not a DP class
        end
        endcase
end

endmodule

`default_nettype wire

//--- src/zap_thumb_pkg.sv
// Types shared by the compressed instruction decoder
// Instruction class of a compressed halfword
// Data processing opcodes, condition codes and shift types
// of the expanded 32-bit instruction

`default_nettype none

package zap_thumb_pkg;

        ////////////////////////////////
        // Decoded class
        ////////////////////////////////

        typedef enum logic [3:0] {
                CLS_NONE          = 4'd0,       // Nothing kept matched
                CLS_SHIFT         = 4'd1,       // LSL/LSR/ASR by immediate
                CLS_ADD_SUB_LO    = 4'd2,       // ADD/SUB low regs or imm3
                CLS_MCAS_IMM      = 4'd3,       // MOV/CMP/ADD/SUB imm8
                CLS_ALU_LO        = 4'd4,       // Sixteen low register ops
                CLS_ALU_HI        = 4'd5,       // ADD/CMP/MOV high regs
                CLS_BRANCH_COND   = 4'd6,
                CLS_BRANCH_NOCOND = 4'd7,
                CLS_BX            = 4'd8,
                CLS_SWI           = 4'd9
        } thumb_class_t;

        ////////////////////////////////
        // 32-bit instruction fields
        ////////////////////////////////

        // Bits 24:21 of a data processing instruction
        typedef enum logic [3:0] {
                ALU_AND = 4'd0,
                ALU_EOR = 4'd1,
                ALU_SUB = 4'd2,
                ALU_RSB = 4'd3,
                ALU_ADD = 4'd4,
                ALU_ADC = 4'd5,
                ALU_SBC = 4'd6,
                ALU_TST = 4'd8,
                ALU_CMP = 4'd10,
                ALU_CMN = 4'd11,
                ALU_ORR = 4'd12,
                ALU_MOV = 4'd13,
                ALU_BIC = 4'd14,
                ALU_MVN = 4'd15
        } alu_op_t;

        // Bits 31:28, AL is the one the expansions use
        typedef enum logic [3:0] {
                EQ, NE, CS, CC,
                MI, PL, VS, VC,
                HI, LS, GE, LT,
                GT, LE, AL, NV
        } cond_t;

        // Bits 6:5 of a shifted register operand
        typedef enum logic [1:0] {
                LSL = 2'd0,
                LSR = 2'd1,
                ASR = 2'd2,
                ROR = 2'd3
        } shift_t;

endpackage

`default_nettype wire

//--- zap_thumb_decoder.f
+incdir+src
src/zap_thumb_pkg.sv
src/zap_thumb_class_decoder.sv
src/zap_thumb_dp_decoder.sv
src/zap_thumb_branch_decoder.sv
src/zap_thumb_decode_stage.sv
src/zap_thumb_decoder.sv
sim/zap_thumb_decoder_assert.sv
sim/zap_thumb_decoder_tb.sv
